//--- program_input.txt
# "test <name>" opens a record, then one line per instruction word in hex,
# optionally followed by the expected write as rd (decimal) and value (hex)
test aluOps
00500093  1 00000005  # addi x1, x0, 5
ffd00113  2 fffffffd  # addi x2, x0, -3
002081b3  3 00000002  # add  x3, x1, x2
40208233  4 00000008  # sub  x4, x1, x2
0020f2b3  5 00000005  # and  x5, x1, x2
0020e333  6 fffffffd  # or   x6, x1, x2
0020c3b3  7 fffffff8  # xor  x7, x1, x2
00112433  8 00000001  # slt  x8, x2, x1
fff0a493  9 00000000  # slti x9, x1, -1
0f03f513 10 000000f0  # andi x10, x7, 0xf0
1000e593 11 00000105  # ori  x11, x1, 0x100
fff0c613 12 fffffffa  # xori x12, x1, -1
123456b7 13 12345000  # lui  x13, 0x12345
00001717 14 00001034  # auipc x14, 0x1
0000006f              # jal  x0, 0
test forwarding
00100093  1 00000001  # addi x1, x0, 1
001080b3  1 00000002  # add  x1, x1, x1
001080b3  1 00000004  # add  x1, x1, x1
00308113  2 00000007  # addi x2, x1, 3
40110533 10 00000003  # sub  x10, x2, x1
00250533 10 0000000a  # add  x10, x10, x2
0000006f              # jal  x0, 0
test loadStore
04000093  1 00000040  # addi x1, x0, 0x40
abcde137  2 abcde000  # lui  x2, 0xabcde
12310113  2 abcde123  # addi x2, x2, 0x123
0020a223              # sw   x2, 4(x1)
0040a183  3 abcde123  # lw   x3, 4(x1)
00118233  4 abcde163  # add  x4, x3, x1
0040a023              # sw   x4, 0(x1)
0000a503 10 abcde163  # lw   x10, 0(x1)
00150513 10 abcde164  # addi x10, x10, 1
0000006f              # jal  x0, 0
test branchJump
00700093  1 00000007  # addi x1, x0, 7
00700113  2 00000007  # addi x2, x0, 7
00208663              # beq  x1, x2, +12
00100193              # addi x3, x0, 1 (skipped)
00200193              # addi x3, x0, 2 (skipped)
00209463              # bne  x1, x2, +8 (falls through)
00300193  3 00000003  # addi x3, x0, 3
00309463              # bne  x1, x3, +8
00900213              # addi x4, x0, 9 (skipped)
00c002ef  5 00000028  # jal  x5, +12
00100313              # addi x6, x0, 1 (skipped)
00200313              # addi x6, x0, 2 (skipped)
04400393  7 00000044  # addi x7, x0, 68
00038467  8 00000038  # jalr x8, 0(x7)
00100493              # addi x9, x0, 1 (skipped)
00200493              # addi x9, x0, 2 (skipped)
00300493              # addi x9, x0, 3 (skipped)
00140513 10 00000039  # addi x10, x8, 1
0000006f              # jal  x0, 0
test zeroReg
00500013              # addi x0, x0, 5
00900093  1 00000009  # addi x1, x0, 9
00108033              # add  x0, x1, x1
00100533 10 00000009  # add  x10, x0, x1
0000006f              # jal  x0, 0

//--- flist.f
rvIsaPkg.sv
rvPipePkg.sv
fetchUnit.sv
decodeUnit.sv
regFile.sv
executeUnit.sv
memoryUnit.sv
hazardUnit.sv
rvCore.sv
tbRvCore.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbRvCore -f flist.f -o simRvCore
output=$(./obj_dir/simRvCore)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

//--- tbRvCore.sv
`timescale 1ns/100ps

module tbRvCore;

    logic                clk;
    logic                arstN;
    rvPipePkg::imemLoadT imemLoad;
    logic [31:0]         a0;
    rvPipePkg::wbTraceT  trace;

    // test records flattened into shared word and write queues
    string               testNames[$];
    int                  progStart[$];
    int                  progLen[$];
    int                  expStart[$];
    int                  expLen[$];
    logic [31:0]         progWords[$];
    rvPipePkg::wbTraceT  expWrites[$];

    int cycles = 0;
    int cycleLimit = 0;
    int testErrors;
    int testsPassed;
    int testsFailed;

    rvCore dut0 (
        .clk(clk),
        .arstN(arstN),
        .imemLoad(imemLoad),
        .a0(a0),
        .trace(trace)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    always @(negedge clk) begin
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic readTests();
        int          fd;
        int          n;
        int          rdNum;
        int          last;
        string       line;
        string       tok;
        string       name;
        logic [31:0] word;
        logic [31:0] val;
        rvPipePkg::wbTraceT expected;
        fd = $fopen("program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open program_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                tok = "";
                n = $fgets(line, fd);
                if (n == 0) break;
                n = $sscanf(line, "%s", tok);
                if (n < 1 || tok.len() == 0 || tok.substr(0, 0) == "#") continue;
                if (tok == "test") begin
                    n = $sscanf(line, "%s %s", tok, name);
                    testNames.push_back(name);
                    progStart.push_back(progWords.size());
                    progLen.push_back(0);
                    expStart.push_back(expWrites.size());
                    expLen.push_back(0);
                end else if (testNames.size() > 0) begin
                    last = testNames.size() - 1;
                    n = $sscanf(line, "%h %d %h", word, rdNum, val);
                    if (n >= 1) begin
                        progWords.push_back(word);
                        progLen[last] = progLen[last] + 1;
                    end
                    if (n == 3) begin
                        expected.valid = 1'b1;
                        expected.rd = 5'(rdNum);
                        expected.data = val;
                        expWrites.push_back(expected);
                        expLen[last] = expLen[last] + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // hold the core in reset while the program is written into imem
    task automatic loadProgram(input int t);
        int len;
        len = progLen[t];
        @(posedge clk);
        arstN <= 1'b0;
        for (int k = 0; k < len || k < 8; k++) begin
            @(posedge clk);
            if (k < len) begin
                imemLoad.we <= 1'b1;
                imemLoad.addr <= 10'(k);
                imemLoad.data <= progWords[progStart[t] + k];
            end else begin
                imemLoad <= '0;
            end
        end
        @(posedge clk);
        imemLoad <= '0;
        arstN <= 1'b1;
    endtask

    task automatic checkTrace(input string name, input rvPipePkg::wbTraceT expected,
                              input rvPipePkg::wbTraceT actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected x%0d = %08h, actual x%0d = %08h",
                     name, expected.rd, expected.data, actual.rd, actual.data);
            testErrors++;
        end
    endtask

    task automatic checkA0(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected a0 = %08h, actual a0 = %08h",
                     name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic runTest(input int t);
        int                 got;
        int                 idle;
        logic [31:0]        expA0;
        rvPipePkg::wbTraceT expected;
        testErrors = 0;
        got = 0;
        idle = 0;
        // a0 ends as the last value written to x10 or zero
        expA0 = '0;
        for (int k = 0; k < expLen[t]; k++) begin
            expected = expWrites[expStart[t] + k];
            if (expected.rd == 5'd10) begin
                expA0 = expected.data;
            end
        end
        loadProgram(t);
        while (idle < 20) begin
            @(negedge clk);
            if (trace.valid) begin
                if (got < expLen[t]) begin
                    checkTrace(testNames[t], expWrites[expStart[t] + got], trace);
                    got++;
                end else begin
                    $display("%s: unexpected extra write of %08h to x%0d",
                             testNames[t], trace.data, trace.rd);
                    testErrors++;
                end
            end
            if (got == expLen[t]) begin
                idle++;
            end
        end
        checkA0(testNames[t], expA0, a0);
        if (testErrors == 0) begin
            $display("test %s: ok, %0d writes checked", testNames[t], got);
            testsPassed++;
        end else begin
            $display("test %s: %0d errors", testNames[t], testErrors);
            testsFailed++;
        end
    endtask

    initial begin
        arstN <= 1'b0;
        imemLoad <= '0;
        testsPassed = 0;
        testsFailed = 0;
        readTests();
        cycleLimit = 40 * progWords.size() + 100 * testNames.size();
        for (int t = 0; t < testNames.size(); t++) begin
            runTest(t);
        end
        $display("%0d tests run, %0d passed, %0d failed",
                 testNames.size(), testsPassed, testsFailed);
        if (testsFailed == 0 && testNames.size() > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- rvCore.sv
`timescale 1ns/100ps

module rvCore #(
    parameter int imemWords = 1024,
    parameter int dmemWords = 1024
) (
    input  logic                clk,
    input  logic                arstN,
    input  rvPipePkg::imemLoadT imemLoad,
    output logic [31:0]         a0,
    output rvPipePkg::wbTraceT  trace
);

    rvPipePkg::ifIdT     ifId;
    rvPipePkg::idExT     idEx;
    rvPipePkg::exMemT    exMem;
    rvPipePkg::redirectT redirect;
    rvPipePkg::hazardT   hazard;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [31:0]         rd1;
    logic [31:0]         rd2;
    logic [31:0]         memFwd;

    fetchUnit #(.imemWords(imemWords)) fetch0 (
        .clk(clk), .arstN(arstN), .imemLoad(imemLoad),
        .hazard(hazard), .redirect(redirect), .ifId(ifId)
    );

    decodeUnit decode0 (
        .clk(clk), .arstN(arstN), .ifId(ifId), .hazard(hazard),
        .rd1(rd1), .rd2(rd2), .rs1(rs1), .rs2(rs2), .idEx(idEx)
    );

    regFile regs0 (
        .clk(clk), .arstN(arstN), .rs1(rs1), .rs2(rs2),
        .wb(trace), .rd1(rd1), .rd2(rd2), .a0(a0)
    );

    executeUnit execute0 (
        .clk(clk), .arstN(arstN), .idEx(idEx), .hazard(hazard),
        .memFwd(memFwd), .wbFwd(trace.data), .exMem(exMem), .redirect(redirect)
    );

    memoryUnit #(.dmemWords(dmemWords)) memory0 (
        .clk(clk), .arstN(arstN), .exMem(exMem), .memFwd(memFwd), .wb(trace)
    );

    hazardUnit hazard0 (
        .idEx(idEx), .rs1(rs1), .rs2(rs2),
        .exRd(exMem.rd), .exRegWrite(exMem.valid && exMem.regWrite),
        .wbRd(trace.rd), .wbRegWrite(trace.valid),
        .redirect(redirect), .hazard(hazard)
    );

endmodule

//--- hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  rvPipePkg::idExT     idEx,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          exRd,
    input  logic                exRegWrite,
    input  logic [4:0]          wbRd,
    input  logic                wbRegWrite,
    input  rvPipePkg::redirectT redirect,
    output rvPipePkg::hazardT   hazard
);

    logic loadUse;

    // memory stage is younger, so it wins over writeback
    function automatic rvPipePkg::fwdSelE fwdFor(input logic [4:0] rs);
        if (exRegWrite && exRd != 5'd0 && exRd == rs) begin
            return rvPipePkg::fwdMem;
        end else if (wbRegWrite && wbRd != 5'd0 && wbRd == rs) begin
            return rvPipePkg::fwdWb;
        end
        return rvPipePkg::fwdReg;
    endfunction

    assign loadUse = idEx.valid && idEx.ctrl.regWrite
                     && (idEx.ctrl.resultSrc == rvPipePkg::resMem)
                     && (idEx.rd != 5'd0) && (idEx.rd == rs1 || idEx.rd == rs2);

    always_comb begin
        hazard.fwdA   = fwdFor(idEx.rs1);
        hazard.fwdB   = fwdFor(idEx.rs2);
        hazard.stallF = loadUse;
        hazard.stallD = loadUse;
        // taken branch or jump kills the two younger instructions
        hazard.flushD = redirect.taken;
        hazard.flushE = redirect.taken || loadUse;
    end

endmodule

//--- memoryUnit.sv
`timescale 1ns/100ps

module memoryUnit #(
    parameter int dmemWords = 1024
) (
    input  logic               clk,
    input  logic               arstN,
    input  rvPipePkg::exMemT   exMem,
    output logic [31:0]        memFwd,
    output rvPipePkg::wbTraceT wb
);

    localparam int idxW = $clog2(dmemWords);

    logic [31:0]      dmem [dmemWords];
    logic [31:0]      readData;
    logic [idxW-1:0]  wordIdx;
    rvPipePkg::memWbT memWb;

    // word addressed, low two address bits ignored
    assign wordIdx  = exMem.aluResult[idxW+1:2];
    assign readData = dmem[wordIdx];
    assign memFwd   = exMem.aluResult;

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[wordIdx] <= exMem.writeData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else begin
            memWb.valid     <= exMem.valid;
            memWb.regWrite  <= exMem.regWrite;
            memWb.resultSrc <= exMem.resultSrc;
            memWb.aluResult <= exMem.aluResult;
            memWb.readData  <= readData;
            memWb.rd        <= exMem.rd;
            memWb.pcPlus4   <= exMem.pcPlus4;
        end
    end

    always_comb begin
        wb.valid = memWb.valid && memWb.regWrite && (memWb.rd != 5'd0);
        wb.rd    = memWb.rd;
        case (memWb.resultSrc)
            rvPipePkg::resMem: wb.data = memWb.readData;
            rvPipePkg::resPc4: wb.data = memWb.pcPlus4;
            default:           wb.data = memWb.aluResult;
        endcase
    end

endmodule

//--- executeUnit.sv
`timescale 1ns/100ps

module executeUnit (
    input  logic                clk,
    input  logic                arstN,
    input  rvPipePkg::idExT     idEx,
    input  rvPipePkg::hazardT   hazard,
    input  logic [31:0]         memFwd,
    input  logic [31:0]         wbFwd,
    output rvPipePkg::exMemT    exMem,
    output rvPipePkg::redirectT redirect
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] jalrSum;
    logic        equal;
    logic        branchTaken;

    function automatic logic [31:0] pickFwd(input rvPipePkg::fwdSelE sel,
                                            input logic [31:0] regVal);
        case (sel)
            rvPipePkg::fwdMem: return memFwd;
            rvPipePkg::fwdWb:  return wbFwd;
            default:           return regVal;
        endcase
    endfunction

    assign srcA = pickFwd(hazard.fwdA, idEx.rd1);
    assign srcB = pickFwd(hazard.fwdB, idEx.rd2);
    assign aluA = idEx.ctrl.aluSrcA ? idEx.pc : srcA;
    assign aluB = idEx.ctrl.aluSrcB ? idEx.imm : srcB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            rvPipePkg::aluSub:   aluResult = aluA - aluB;
            rvPipePkg::aluAnd:   aluResult = aluA & aluB;
            rvPipePkg::aluOr:    aluResult = aluA | aluB;
            rvPipePkg::aluXor:   aluResult = aluA ^ aluB;
            rvPipePkg::aluSlt:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            rvPipePkg::aluPassB: aluResult = aluB;
            default:             aluResult = aluA + aluB;
        endcase
    end

    // branch compare uses forwarded registers directly
    assign equal       = (srcA == srcB);
    assign branchTaken = idEx.ctrl.branch && (idEx.ctrl.branchNe ? !equal : equal);
    assign jalrSum     = srcA + idEx.imm;

    assign redirect.taken  = idEx.valid && (idEx.ctrl.jump || branchTaken);
    assign redirect.target = idEx.ctrl.jalr ? {jalrSum[31:1], 1'b0} : idEx.pc + idEx.imm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.regWrite  <= idEx.valid && idEx.ctrl.regWrite;
            exMem.memWrite  <= idEx.valid && idEx.ctrl.memWrite;
            exMem.resultSrc <= idEx.ctrl.resultSrc;
            exMem.aluResult <= aluResult;
            exMem.writeData <= srcB;
            exMem.rd        <= idEx.rd;
            exMem.pcPlus4   <= idEx.pcPlus4;
        end
    end

endmodule

//--- regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic               clk,
    input  logic               arstN,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    input  rvPipePkg::wbTraceT wb,
    output logic [31:0]        rd1,
    output logic [31:0]        rd2,
    output logic [31:0]        a0
);

    logic [31:0] regs [31:1];

    // x0 reads zero, a same-cycle writeback is bypassed to the read port
    function automatic logic [31:0] readReg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wb.valid && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rd1 = readReg(rs1);
    assign rd2 = readReg(rs2);
    assign a0  = regs[10];

endmodule

//--- decodeUnit.sv
`timescale 1ns/100ps

module decodeUnit (
    input  logic              clk,
    input  logic              arstN,
    input  rvPipePkg::ifIdT   ifId,
    input  rvPipePkg::hazardT hazard,
    input  logic [31:0]       rd1,
    input  logic [31:0]       rd2,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output rvPipePkg::idExT   idEx
);

    rvIsaPkg::instrT   fields;
    rvIsaPkg::immKindE immKind;
    rvPipePkg::ctrlT   ctrl;
    logic [31:0]       imm;
    logic [31:0]       ins;

    function automatic rvPipePkg::aluOpE aluFromF3(input logic [2:0] f3, input logic sub);
        case (f3)
            rvIsaPkg::f3AddSub: return sub ? rvPipePkg::aluSub : rvPipePkg::aluAdd;
            rvIsaPkg::f3Slt:    return rvPipePkg::aluSlt;
            rvIsaPkg::f3Xor:    return rvPipePkg::aluXor;
            rvIsaPkg::f3Or:     return rvPipePkg::aluOr;
            rvIsaPkg::f3And:    return rvPipePkg::aluAnd;
            default:            return rvPipePkg::aluAdd;
        endcase
    endfunction

    assign ins    = ifId.instr;
    assign fields = ins;
    assign rs1    = fields.rs1;
    assign rs2    = fields.rs2;

    always_comb begin
        ctrl    = '0;
        immKind = rvIsaPkg::immI;
        if (ifId.valid) begin
            case (fields.opcode)
                rvIsaPkg::opReg: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = aluFromF3(fields.funct3, fields.funct7[5]);
                end
                rvIsaPkg::opImm: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    // no subi, bit 30 belongs to the immediate here
                    ctrl.aluOp    = aluFromF3(fields.funct3, 1'b0);
                end
                rvIsaPkg::opLui: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.aluOp    = rvPipePkg::aluPassB;
                    immKind       = rvIsaPkg::immU;
                end
                rvIsaPkg::opAuipc: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcA  = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    immKind       = rvIsaPkg::immU;
                end
                rvIsaPkg::opLoad: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.resultSrc = rvPipePkg::resMem;
                end
                rvIsaPkg::opStore: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    immKind       = rvIsaPkg::immS;
                end
                rvIsaPkg::opBranch: begin
                    ctrl.branch   = 1'b1;
                    ctrl.branchNe = (fields.funct3 == rvIsaPkg::f3Bne);
                    ctrl.aluOp    = rvPipePkg::aluSub;
                    immKind       = rvIsaPkg::immB;
                end
                rvIsaPkg::opJal: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.jump      = 1'b1;
                    ctrl.resultSrc = rvPipePkg::resPc4;
                    immKind        = rvIsaPkg::immJ;
                end
                rvIsaPkg::opJalr: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.jump      = 1'b1;
                    ctrl.jalr      = 1'b1;
                    ctrl.resultSrc = rvPipePkg::resPc4;
                end
                default: ctrl = '0;
            endcase
        end
    end

    always_comb begin
        case (immKind)
            rvIsaPkg::immS: imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            rvIsaPkg::immB: imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            rvIsaPkg::immU: imm = {ins[31:12], 12'b0};
            rvIsaPkg::immJ: imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:        imm = {{20{ins[31]}}, ins[31:20]};
        endcase
    end

    // decode/execute register, flushE turns the slot into a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            idEx.valid   <= ifId.valid && !hazard.flushE;
            idEx.ctrl    <= ctrl;
            idEx.rd1     <= rd1;
            idEx.rd2     <= rd2;
            idEx.imm     <= imm;
            idEx.rs1     <= fields.rs1;
            idEx.rs2     <= fields.rs2;
            idEx.rd      <= fields.rd;
            idEx.pc      <= ifId.pc;
            idEx.pcPlus4 <= ifId.pcPlus4;
            if (hazard.flushE) begin
                idEx.ctrl.regWrite <= 1'b0;
                idEx.ctrl.memWrite <= 1'b0;
            end
        end
    end

endmodule

//--- fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit #(
    parameter int imemWords = 1024
) (
    input  logic                clk,
    input  logic                arstN,
    input  rvPipePkg::imemLoadT imemLoad,
    input  rvPipePkg::hazardT   hazard,
    input  rvPipePkg::redirectT redirect,
    output rvPipePkg::ifIdT     ifId
);

    localparam int idxW = $clog2(imemWords);

    logic [31:0] imem [imemWords];
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcNext;
    logic [31:0] instr;

    // program load is only accepted while the core is held in reset
    always_ff @(posedge clk) begin
        if (!arstN && imemLoad.we) begin
            imem[imemLoad.addr[idxW-1:0]] <= imemLoad.data;
        end
    end

    assign instr   = imem[pc[idxW+1:2]];
    assign pcPlus4 = pc + 32'd4;
    assign pcNext  = redirect.taken ? redirect.target : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!hazard.stallF) begin
            pc <= pcNext;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else if (hazard.flushD) begin
            ifId <= '0;
        end else if (!hazard.stallD) begin
            ifId.valid   <= 1'b1;
            ifId.instr   <= instr;
            ifId.pc      <= pc;
            ifId.pcPlus4 <= pcPlus4;
        end
    end

endmodule

//--- rvPipePkg.sv
package rvPipePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOpE;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPc4
    } resultSrcE;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelE;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      jump;
        logic      branch;
        logic      branchNe;
        logic      jalr;
        // aluSrcA selects pc, aluSrcB selects the immediate
        logic      aluSrcA;
        logic      aluSrcB;
        aluOpE     aluOp;
        resultSrcE resultSrc;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
    } ifIdT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
    } idExT;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        logic        memWrite;
        resultSrcE   resultSrc;
        logic [31:0] aluResult;
        logic [31:0] writeData;
        logic [4:0]  rd;
        logic [31:0] pcPlus4;
    } exMemT;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        resultSrcE   resultSrc;
        logic [31:0] aluResult;
        logic [31:0] readData;
        logic [4:0]  rd;
        logic [31:0] pcPlus4;
    } memWbT;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirectT;

    typedef struct packed {
        logic   stallF;
        logic   stallD;
        logic   flushD;
        logic   flushE;
        fwdSelE fwdA;
        fwdSelE fwdB;
    } hazardT;

    typedef struct packed {
        logic        we;
        logic [9:0]  addr;
        logic [31:0] data;
    } imemLoadT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wbTraceT;

endpackage

//--- rvIsaPkg.sv
package rvIsaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeE;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immKindE;

    // funct3 values used by decode
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Bne    = 3'b001;

    // R-type field layout, the other formats share rd/rs1/rs2/funct3 positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeE     opcode;
    } instrT;

endpackage
